// File: design/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer import stepper_pkg::*; (
  input  logic               step,
  input  logic               rst_n,
  input  logic               step_tick,
  input  logic               enable,
  input  logic               dir,        // 1 walks the table upward
  input  logic [MSTEP_W-1:0] microsteps,
  output logic               phase_a1,
  output logic               phase_a2,
  output logic               phase_b1,
  output logic               phase_b2,
  output logic [PHASE_W-1:0] phase_idx
);

  logic [PHASE_W-1:0] inc;
  logic [PHASE_W-1:0] idx_next;
  logic [COIL_W-1:0]  coil_q;

  assign inc = phase_inc(microsteps); // 4, 2 or 1 entries

  // Index wraps naturally in 3 bits
  always_comb begin
    idx_next = phase_idx;
    if (step_tick) begin
      idx_next = dir ? phase_idx + inc : phase_idx - inc;
    end
  end

  always_ff @(posedge step or negedge rst_n) begin
    if (!rst_n) begin
      phase_idx <= '0;
      coil_q    <= '0; // All coils off
    end else begin
      phase_idx <= idx_next;
      // Look up the new entry so the coils follow the tick by one cycle
      if (enable) begin
        coil_q <= COIL_TABLE[idx_next];
      end else begin
        coil_q <= '0; // Bridges released
      end
    end
  end

  assign phase_a1 = coil_q[COIL_A1];
  assign phase_a2 = coil_q[COIL_A2];
  assign phase_b1 = coil_q[COIL_B1];
  assign phase_b2 = coil_q[COIL_B2];

endmodule

// File: design/step_rate_gen.sv
`timescale 1ns/1ps

module step_rate_gen import stepper_pkg::*; (
  input  logic                step,
  input  logic                rst_n,
  input  logic                enable,
  input  logic                start,      // Load step_count
  input  logic [STEPS_W-1:0]  step_count,
  input  logic [PERIOD_W-1:0] period,     // Cycles per step
  output logic                step_tick,
  output logic                busy,
  output logic [STEPS_W-1:0]  steps_left
);

  logic [PERIOD_W-1:0] interval_cnt;
  logic [PERIOD_W-1:0] eff_period;

  assign eff_period = (period == '0) ? PERIOD_W'(1) : period; // Zero runs as one

  always_ff @(posedge step or negedge rst_n) begin
    if (!rst_n) begin
      interval_cnt <= '0;
      steps_left   <= '0;
      busy         <= 1'b0;
      step_tick    <= 1'b0;
    end else begin
      step_tick <= 1'b0;
      if (start) begin
        // New count wins even mid-move
        interval_cnt <= eff_period;
        steps_left   <= step_count;
        busy         <= (step_count != '0);
      end else if (busy) begin
        if (step_tick && steps_left == '0) begin
          busy <= 1'b0; // Drop one cycle after the final tick
        end else if (enable && steps_left != '0) begin
          if (interval_cnt <= PERIOD_W'(1)) begin
            step_tick    <= 1'b1;
            interval_cnt <= eff_period;   // Next interval
            steps_left   <= steps_left - 1'b1;
          end else begin
            interval_cnt <= interval_cnt - 1'b1;
          end
        end
        // Enable low holds both counters
      end
    end
  end

endmodule

// File: design/stepper_pkg.sv
package stepper_pkg;

  // AXI4-Lite bus shape
  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Register byte offsets, one 32-bit word each
  localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL    = 8'h00;
  localparam logic [AXI_ADDR_W-1:0] ADDR_PERIOD  = 8'h04;
  localparam logic [AXI_ADDR_W-1:0] ADDR_STEPS   = 8'h08;
  localparam logic [AXI_ADDR_W-1:0] ADDR_CURRENT = 8'h0C;
  localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS  = 8'h10; // Read only

  // CTRL fields
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_DIR_BIT    = 1; // 1 = forward through the table
  localparam int CTRL_MSTEP_LSB  = 2; // Bits 4:2

  localparam int MSTEP_W   = 3;
  localparam int PHASE_W   = 3;
  localparam int PERIOD_W  = 16;
  localparam int STEPS_W   = 16;
  localparam int CURRENT_W = 8;

  localparam int CUR_A_LSB = 0; // CURRENT[7:0]
  localparam int CUR_B_LSB = 8; // CURRENT[15:8]

  // STATUS fields
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_PHASE_LSB = 1;
  localparam int STAT_STEPS_LSB = 16;

  // Coil word layout
  localparam int COIL_W  = 4;
  localparam int COIL_A1 = 0;
  localparam int COIL_A2 = 1;
  localparam int COIL_B1 = 2;
  localparam int COIL_B2 = 3;

  // Half-step drive pattern, {b2, b1, a2, a1}
  localparam logic [COIL_W-1:0] COIL_TABLE [0:(1<<PHASE_W)-1] = '{
    4'b1010, 4'b0010, 4'b0110, 4'b0100,
    4'b0101, 4'b0001, 4'b1001, 4'b1000
  };

  localparam int MSTEP_MAX = 2; // Finest mode the table supports

  // Table entries to move per step tick
  function automatic logic [PHASE_W-1:0] phase_inc(input logic [MSTEP_W-1:0] mode);
    logic [MSTEP_W-1:0] m;
    m = (mode > MSTEP_W'(MSTEP_MAX)) ? MSTEP_W'(MSTEP_MAX) : mode; // Clamp
    return PHASE_W'(4) >> m; // 4, 2 or 1
  endfunction

endpackage

// File: design/stepper_regs.sv
`timescale 1ns/1ps

module stepper_regs import stepper_pkg::*; (
  input  logic                  step,
  input  logic                  rst_n,
  // Write address and data
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [AXI_STRB_W-1:0] wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  // Write response
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  // Read channels
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  // Status from the motor blocks
  input  logic                  busy,
  input  logic [STEPS_W-1:0]    steps_left,
  input  logic [PHASE_W-1:0]    phase_idx,
  // Configuration to the motor blocks
  output logic                  enable,
  output logic                  dir,
  output logic [MSTEP_W-1:0]    microsteps,
  output logic [PERIOD_W-1:0]   period,
  output logic [STEPS_W-1:0]    step_count,
  output logic                  start,
  output logic [CURRENT_W-1:0]  current_a,
  output logic [CURRENT_W-1:0]  current_b
);

  logic [AXI_DATA_W-1:0] ctrl_q;
  logic [AXI_DATA_W-1:0] period_q;
  logic [AXI_DATA_W-1:0] steps_q;
  logic [AXI_DATA_W-1:0] current_q;
  logic [AXI_DATA_W-1:0] status_word;
  logic [AXI_DATA_W-1:0] rd_word;
  logic                  wr_hs; // Write accepted this cycle
  logic                  rd_hs; // Read accepted this cycle

  // Byte-lane merge of new data into a stored word
  function automatic logic [AXI_DATA_W-1:0] merge_strb(
    input logic [AXI_DATA_W-1:0] old_val,
    input logic [AXI_DATA_W-1:0] new_val,
    input logic [AXI_STRB_W-1:0] strb
  );
    logic [AXI_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < AXI_STRB_W; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign wready = awready;                    // Both ready strobes move together
  assign wr_hs  = awready && awvalid && wvalid;
  assign bresp  = RESP_OKAY;

  // Write path, single-cycle ready then held response
  always_ff @(posedge step or negedge rst_n) begin
    if (!rst_n) begin
      awready   <= 1'b0;
      bvalid    <= 1'b0;
      start     <= 1'b0;
      ctrl_q    <= '0; // Motor disabled out of reset
      period_q  <= '0;
      steps_q   <= '0;
      current_q <= '0;
    end else begin
      awready <= awvalid && wvalid && !awready && !bvalid;
      start   <= 1'b0; // One-cycle pulse
      if (wr_hs) begin
        bvalid <= 1'b1;
        case (awaddr)
          ADDR_CTRL:    ctrl_q    <= merge_strb(ctrl_q, wdata, wstrb);
          ADDR_PERIOD:  period_q  <= merge_strb(period_q, wdata, wstrb);
          ADDR_CURRENT: current_q <= merge_strb(current_q, wdata, wstrb);
          ADDR_STEPS: begin
            steps_q <= merge_strb(steps_q, wdata, wstrb);
            start   <= 1'b1; // Kick off or reload a move
          end
          default: ; // STATUS and holes swallow the write
        endcase
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Live status word
  always_comb begin
    status_word = '0;
    status_word[STAT_BUSY_BIT] = busy;
    status_word[STAT_PHASE_LSB +: PHASE_W] = phase_idx;
    status_word[STAT_STEPS_LSB +: STEPS_W] = steps_left;
  end

  // Read mux
  always_comb begin
    case (araddr)
      ADDR_CTRL:    rd_word = ctrl_q;
      ADDR_PERIOD:  rd_word = period_q;
      ADDR_STEPS:   rd_word = steps_q;
      ADDR_CURRENT: rd_word = current_q;
      ADDR_STATUS:  rd_word = status_word;
      default:      rd_word = '0; // Unmapped reads as zero
    endcase
  end

  assign arready = !rvalid; // Ready unless a response waits
  assign rd_hs   = arvalid && arready;
  assign rresp   = RESP_OKAY;

  always_ff @(posedge step or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_hs) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Read data captured at the handshake
  always_ff @(posedge step) begin
    if (rd_hs) begin
      rdata <= rd_word;
    end
  end

  // Field extraction
  assign enable     = ctrl_q[CTRL_ENABLE_BIT];
  assign dir        = ctrl_q[CTRL_DIR_BIT];
  assign microsteps = ctrl_q[CTRL_MSTEP_LSB +: MSTEP_W];
  assign period     = period_q[PERIOD_W-1:0];
  assign step_count = steps_q[STEPS_W-1:0];
  assign current_a  = current_q[CUR_A_LSB +: CURRENT_W];
  assign current_b  = current_q[CUR_B_LSB +: CURRENT_W];

endmodule

// File: design/stepper_top.sv
`timescale 1ns/1ps

module stepper_top import stepper_pkg::*; (
  input  logic                  step,
  input  logic                  rst_n,
  // AXI4-Lite slave
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [AXI_STRB_W-1:0] wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  // Motor side
  output logic                  phase_a1,
  output logic                  phase_a2,
  output logic                  phase_b1,
  output logic                  phase_b2,
  output logic                  vref_a,
  output logic                  vref_b,
  output logic                  busy
);

  logic                 enable;
  logic                 dir;
  logic [MSTEP_W-1:0]   microsteps;
  logic [PERIOD_W-1:0]  period;
  logic [STEPS_W-1:0]   step_count;
  logic                 start;
  logic [CURRENT_W-1:0] current_a;
  logic [CURRENT_W-1:0] current_b;
  logic                 step_tick;
  logic [STEPS_W-1:0]   steps_left;
  logic [PHASE_W-1:0]   phase_idx;

  // Register file and bus slave
  stepper_regs u_regs (
    .step(step), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .busy(busy), .steps_left(steps_left), .phase_idx(phase_idx),
    .enable(enable), .dir(dir), .microsteps(microsteps), .period(period),
    .step_count(step_count), .start(start),
    .current_a(current_a), .current_b(current_b)
  );

  // Step tick source
  step_rate_gen u_rate (
    .step(step), .rst_n(rst_n), .enable(enable), .start(start),
    .step_count(step_count), .period(period),
    .step_tick(step_tick), .busy(busy), .steps_left(steps_left)
  );

  phase_sequencer u_seq (
    .step(step), .rst_n(rst_n), .step_tick(step_tick), .enable(enable),
    .dir(dir), .microsteps(microsteps),
    .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2),
    .phase_idx(phase_idx)
  );

  // One current reference per winding
  vref_pwm vref_a_gen (.step(step), .rst_n(rst_n), .level(current_a), .vref(vref_a));
  vref_pwm vref_b_gen (.step(step), .rst_n(rst_n), .level(current_b), .vref(vref_b));

endmodule

// File: design/vref_pwm.sv
`timescale 1ns/1ps

module vref_pwm import stepper_pkg::*; (
  input  logic                 step,
  input  logic                 rst_n,
  input  logic [CURRENT_W-1:0] level, // Duty in 1/256 steps
  output logic                 vref
);

  logic [CURRENT_W-1:0] cnt; // Free-running, 256-cycle frame

  always_ff @(posedge step or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      vref <= 1'b0;
    end else begin
      cnt  <= cnt + 1'b1;
      vref <= (cnt < level); // High for level counts per frame
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the stepper testbench, run it into sim.log and check the result
rm -f sim.log
verilator --binary --assert --top-module stepper_tb -f stepper_top.f -o stepper_sim \
  && ./obj_dir/stepper_sim +verilator+error+limit+100 > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: stepper_top.f
design/stepper_pkg.sv
design/vref_pwm.sv
design/phase_sequencer.sv
design/step_rate_gen.sv
design/stepper_regs.sv
design/stepper_top.sv
tb/stepper_properties.sv
tb/stepper_tb.sv

// File: tb/stepper_properties.sv
`timescale 1ns/1ps

module stepper_properties (
  input logic step,
  input logic rst_n,
  input logic enable,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  int failures = 0; // Total of failed assertions

  // No shoot-through on either H bridge
  bridge_a: assert property (@(posedge step) disable iff (!rst_n) !(phase_a1 && phase_a2))
    else begin
      failures++;
      $error("Phase A drives a1 and a2 together");
    end
  bridge_b: assert property (@(posedge step) disable iff (!rst_n) !(phase_b1 && phase_b2))
    else begin
      failures++;
      $error("Phase B drives b1 and b2 together");
    end

  // Disabled driver releases all coils on the next cycle
  coils_off: assert property (@(posedge step) disable iff (!rst_n)
    !enable |=> {phase_b2, phase_b1, phase_a2, phase_a1} == 4'b0000)
    else begin
      failures++;
      $error("Coils still driven after enable went low");
    end

  // Responses wait for the master
  b_hold: assert property (@(posedge step) disable iff (!rst_n) bvalid && !bready |=> bvalid)
    else begin
      failures++;
      $error("bvalid dropped before bready");
    end
  r_hold: assert property (@(posedge step) disable iff (!rst_n) rvalid && !rready |=> rvalid)
    else begin
      failures++;
      $error("rvalid dropped before rready");
    end

endmodule

// File: tb/stepper_tb.sv
`timescale 1ns/1ps

module stepper_tb import stepper_pkg::*; ();

  localparam int MAX_STEPS  = 20;
  localparam int MAX_PERIOD = 8;
  localparam int N_MOVES    = 5;
  // Moves at worst case, plus gating pause, PWM windows and bus traffic
  localparam int WATCHDOG_CYCLES = N_MOVES * MAX_STEPS * MAX_PERIOD + 3000;

  logic                  step = 1'b0;
  logic                  rst_n;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic [AXI_STRB_W-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  phase_a1;
  logic                  phase_a2;
  logic                  phase_b1;
  logic                  phase_b2;
  logic                  vref_a;
  logic                  vref_b;
  logic                  busy;

  int                err_count = 0;
  int                check_count = 0;
  int                model_idx = 0; // Reference phase accumulator
  string             check_name;
  logic [COIL_W-1:0] exp_coils;
  event              do_check;
  event              check_done;

  stepper_top DUT (.*);

  bind stepper_top stepper_properties props (
    .step(step), .rst_n(rst_n), .enable(enable),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2),
    .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
  );

  always #50 step = ~step; // 100 ns period

  // Table entries per tick, 4 for full step down to 1 at the finest mode
  function automatic int step_size(input int mode);
    if (mode >= 2) return 1;
    return (mode == 1) ? 2 : 4;
  endfunction

  function automatic int expected_index(input int start_idx, input int steps, input bit fwd,
                                        input int mode);
    int delta;
    delta = (steps * step_size(mode)) % 8;
    return fwd ? (start_idx + delta) % 8 : (start_idx + 8 - delta) % 8;
  endfunction

  function automatic logic [COIL_W-1:0] expected_coils(input int start_idx, input int steps,
                                                      input bit fwd, input int mode, input bit en);
    if (!en) return '0; // Released bridges
    return COIL_TABLE[expected_index(start_idx, steps, fwd, mode)];
  endfunction

  function automatic logic [AXI_DATA_W-1:0] ctrl_word(input int mode, input bit fwd, input bit en);
    return 32'((mode << CTRL_MSTEP_LSB) | (int'(fwd) << CTRL_DIR_BIT) | int'(en));
  endfunction

  task automatic expect_eq(input string name, input int exp_val, input int act_val);
    check_count++;
    if (act_val !== exp_val) begin
      err_count++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp_val, act_val);
    end
  endtask

  // Master leaves bready low until bvalid shows, then accepts the response
  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
    @(posedge step);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge step); while (!awready); // Handshake edge
    expect_eq("wready with awready", 1, int'(wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge step); while (!bvalid);
    expect_eq("write response", int'(RESP_OKAY), int'(bresp));
    bready <= 1'b1;
    @(posedge step);
    bready <= 1'b0;
  endtask

  // Same back-pressure on the read response
  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data);
    @(posedge step);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge step); while (!arready);
    arvalid <= 1'b0;
    do @(posedge step); while (!rvalid);
    data = rdata;
    expect_eq("read response", int'(RESP_OKAY), int'(rresp));
    rready <= 1'b1;
    @(posedge step);
    rready <= 1'b0;
  endtask

  task automatic check_readback(input string name, input logic [AXI_ADDR_W-1:0] addr);
    logic [AXI_DATA_W-1:0] val;
    logic [AXI_DATA_W-1:0] rd;
    val = $urandom();
    axi_write(addr, val);
    axi_read(addr, rd);
    expect_eq(name, val, rd);
  endtask

  task automatic wait_idle();
    do @(posedge step); while (busy);
  endtask

  // Update the model and hand off to the compare process
  task automatic finish_move(input string name, input int mode, input bit fwd, input int steps);
    exp_coils  = expected_coils(model_idx, steps, fwd, mode, 1'b1);
    model_idx  = expected_index(model_idx, steps, fwd, mode);
    check_name = name;
    -> do_check;
    @(check_done);
  endtask

  task automatic run_move(input string name, input int mode, input bit fwd, input int steps,
                          input int per);
    axi_write(ADDR_PERIOD, 32'(per));
    axi_write(ADDR_CTRL, ctrl_word(mode, fwd, 1'b1));
    axi_write(ADDR_STEPS, 32'(steps)); // Starts the move
    wait_idle();
    finish_move(name, mode, fwd, steps);
  endtask

  initial begin : compare
    logic [AXI_DATA_W-1:0] status;
    forever begin
      @(do_check);
      axi_read(ADDR_STATUS, status);
      expect_eq({check_name, " coils"}, int'(exp_coils),
                int'({phase_b2, phase_b1, phase_a2, phase_a1}));
      expect_eq({check_name, " phase index"}, model_idx,
                int'(status[STAT_PHASE_LSB +: PHASE_W]));
      expect_eq({check_name, " steps left"}, 0, int'(status[STAT_STEPS_LSB +: STEPS_W]));
      expect_eq({check_name, " busy"}, 0, int'(status[STAT_BUSY_BIT]));
      -> check_done;
    end
  end

  initial begin : stimulus
    logic [AXI_DATA_W-1:0] rd;
    int n;
    int lvl_a;
    int lvl_b;
    int hi_a;
    int hi_b;
    void'($urandom(16));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '1; // Full-word writes
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (4) @(posedge step);
    rst_n <= 1'b1;

    axi_read(ADDR_STATUS, rd);
    expect_eq("busy after reset", 0, int'(rd[STAT_BUSY_BIT]));
    check_readback("ctrl readback", ADDR_CTRL);
    check_readback("period readback", ADDR_PERIOD);
    check_readback("current readback", ADDR_CURRENT);
    axi_write(8'h20, 32'hFFFF_FFFF); // Hole, dropped
    axi_read(8'h20, rd);
    expect_eq("unmapped read", 0, rd);

    run_move("full step fwd", 0, 1'b1, $urandom_range(MAX_STEPS, 1), $urandom_range(MAX_PERIOD, 1));
    run_move("half step rev", 1, 1'b0, $urandom_range(MAX_STEPS, 1), $urandom_range(MAX_PERIOD, 1));
    run_move("quarter step rev", 2, 1'b0, $urandom_range(MAX_STEPS, 1),
             $urandom_range(MAX_PERIOD, 1));
    run_move("mode 5 rev", 5, 1'b0, $urandom_range(MAX_STEPS, 1), $urandom_range(MAX_PERIOD, 1));

    // Move started while disabled must hold
    n = $urandom_range(MAX_STEPS, 2);
    axi_write(ADDR_PERIOD, 32'd2);
    axi_write(ADDR_CTRL, ctrl_word(1, 1'b1, 1'b0));
    axi_write(ADDR_STEPS, 32'(n));
    repeat (4 * n) @(posedge step); // Twice the move length
    axi_read(ADDR_STATUS, rd);
    expect_eq("gated coils", int'(expected_coils(model_idx, n, 1'b1, 1, 1'b0)),
              int'({phase_b2, phase_b1, phase_a2, phase_a1}));
    expect_eq("gated busy", 1, int'(busy));
    expect_eq("gated steps left", n, int'(rd[STAT_STEPS_LSB +: STEPS_W]));
    expect_eq("gated phase index", model_idx, int'(rd[STAT_PHASE_LSB +: PHASE_W]));
    axi_write(ADDR_CTRL, ctrl_word(1, 1'b1, 1'b1)); // Resume
    wait_idle();
    finish_move("gated move resumed", 1, 1'b1, n);

    repeat (2) begin
      lvl_a = $urandom_range(255, 0);
      lvl_b = $urandom_range(255, 0);
      axi_write(ADDR_CURRENT, 32'((lvl_b << CUR_B_LSB) | (lvl_a << CUR_A_LSB)));
      repeat (2) @(posedge step); // Level reaches the comparator
      hi_a = 0;
      hi_b = 0;
      repeat (256) begin
        @(posedge step);
        hi_a += int'(vref_a);
        hi_b += int'(vref_b);
      end
      expect_eq("vref a duty", lvl_a, hi_a);
      expect_eq("vref b duty", lvl_b, hi_b);
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, err_count, DUT.props.failures);
    if (err_count == 0 && DUT.props.failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge step);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule
